//--- common/bus_pkg.sv
// Shared widths, frame constants and types for the pin-limited bus bridge.
// Every RTL file pulls this in with a wildcard import in its module header.
// A bus cycle is a fixed frame of FRAME_PHASES clocks over 8-bit pins.

package bus_pkg;

  // widths
  localparam int BYTE_W    = 8;
  localparam int WORD_W    = 32;
  localparam int PHASE_W   = 4;
  localparam int NUM_LANES = 4;  // bytes per word

  typedef logic [BYTE_W-1:0]    byte_t;
  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [PHASE_W-1:0]   phase_t;
  typedef logic [NUM_LANES-1:0] lane_sel_t;  // one bit per byte lane

  // frame layout, phase 0 is the core step slot
  localparam int     FRAME_PHASES = 10;
  localparam phase_t ADDR_PHASE0  = 4'd1;  // address + write data, lsb first
  localparam phase_t MARK_PHASE   = 4'd5;  // direction marker on addr pins
  localparam phase_t READ_PHASE0  = 4'd6;  // read bytes captured, lsb first

  // core memory map
  localparam word_t STORE_BASE = 32'h8000_0000;
  localparam word_t PC_STEP    = 32'd4;

  // the core alternates a read cycle and a write cycle
  typedef enum logic {
    ST_FETCH = 1'b0,  // read word at pc
    ST_STORE = 1'b1   // write acc to STORE_BASE + pc
  } core_state_e;

endpackage : bus_pkg

//--- hw/bus_sequencer.sv
// Frame sequencer for the bus bridge.
// Counts the ten phases of a bus frame, gives the core a one-cycle step
// strobe in phase 0 and decodes the per-lane address and read selects.

`timescale 1ns/1ps

module bus_sequencer
  import bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  output phase_t    phase,
  output logic      core_step,
  output lane_sel_t addr_sel,
  output lane_sel_t read_sel
);

  logic frame_done;  // at least one full frame seen since reset
  logic last_phase;

  assign last_phase = (phase == phase_t'(FRAME_PHASES - 1));

  // phase counter, wraps after the last capture phase
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (last_phase) begin
      phase <= '0;
    end else begin
      phase <= phase + phase_t'(1);
    end
  end

  // the first phase 0 after reset has no captured read word yet
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      frame_done <= 1'b0;
    end else if (last_phase) begin
      frame_done <= 1'b1;
    end
  end

  assign core_step = frame_done && (phase == '0);

  // one-hot lane selects
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      addr_sel[i] = (phase == ADDR_PHASE0 + phase_t'(i));
      read_sel[i] = (phase == READ_PHASE0 + phase_t'(i));
    end
  end

endmodule : bus_sequencer

//--- hw/byte_lane/byte_lane.sv
// One byte slice of the bridge bus.
// Drives its address and write data byte while its address phase is active
// and zero otherwise, so the lane outputs can simply be OR-merged.
// Holds the read byte captured from the data pins in its read phase.

`timescale 1ns/1ps

module byte_lane
  import bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  byte_t addr_byte,
  input  byte_t wdata_byte,
  input  logic  addr_sel,
  input  logic  read_sel,
  input  byte_t data_in,
  output byte_t lane_addr,
  output byte_t lane_data,
  output byte_t lane_rdata
);

  byte_t rdata_q;

  // gated outputs towards the pin mux
  always_comb begin
    if (addr_sel) begin
      lane_addr = addr_byte;
      lane_data = wdata_byte;
    end else begin
      lane_addr = '0;
      lane_data = '0;
    end
  end

  // read capture, loaded on the edge that ends this lane's read phase
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (read_sel) begin
      rdata_q <= data_in;
    end
  end

  assign lane_rdata = rdata_q;

endmodule : byte_lane

//--- hw/pin_mux.sv
// Pin multiplexer for the bus bridge.
// ORs the gated lane buses onto the address and data pins, puts the
// direction marker on the address pins in MARK_PHASE and masks the data
// pins in read frames. All pin outputs leave through one register stage.

`timescale 1ns/1ps

module pin_mux
  import bus_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  phase_t phase,
  input  logic   write,
  input  byte_t  lane_addr [NUM_LANES],
  input  byte_t  lane_data [NUM_LANES],
  output byte_t  addr_pins,
  output byte_t  data_out,
  output logic   data_oe,
  output logic   addr_strobe
);

  byte_t addr_or;
  byte_t data_or;
  byte_t addr_next;
  byte_t data_next;

  // only one lane is non-zero at a time
  always_comb begin
    addr_or = '0;
    data_or = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      addr_or = addr_or | lane_addr[i];
      data_or = data_or | lane_data[i];
    end
  end

  always_comb begin
    if (phase == MARK_PHASE) begin
      addr_next = byte_t'(write);  // 1 = write frame, 0 = read frame
      data_next = '0;
    end else begin
      addr_next = addr_or;
      data_next = write ? data_or : '0;  // data pins idle on reads
    end
  end

  // output register, pins lag the phase by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_pins   <= '0;
      data_out    <= '0;
      data_oe     <= 1'b0;
      addr_strobe <= 1'b0;
    end else begin
      addr_pins   <= addr_next;
      data_out    <= data_next;
      data_oe     <= write;  // held for the whole frame
      addr_strobe <= (phase == ADDR_PHASE0);
    end
  end

endmodule : pin_mux

//--- hw/accumulator_core.sv
// Read-accumulate-store core behind the bus bridge.
// Alternates a read of the word at pc with a write of the running sum to
// STORE_BASE + pc, then moves pc on by PC_STEP.
// Advances only on step, so address, data and direction stay fixed for a
// whole bus frame.

`timescale 1ns/1ps

module accumulator_core
  import bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  step,
  input  word_t rdata,
  output word_t addr,
  output word_t wdata,
  output logic  write
);

  core_state_e state;
  word_t       pc;
  word_t       acc;

  // state machine, one transition per bus frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_FETCH;
    end else if (step) begin
      case (state)
        ST_FETCH: state <= ST_STORE;
        ST_STORE: state <= ST_FETCH;
        default:  state <= ST_FETCH;
      endcase
    end
  end

  // accumulate the word returned by the read frame
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (step && (state == ST_FETCH)) begin
      acc <= acc + rdata;  // wraps at 32 bits
    end
  end

  // pc moves on once the store has gone out
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (step && (state == ST_STORE)) begin
      pc <= pc + PC_STEP;
    end
  end

  // bus request for the current frame
  always_comb begin
    case (state)
      ST_STORE: begin
        addr  = STORE_BASE + pc;
        wdata = acc;
        write = 1'b1;
      end
      default: begin
        addr  = pc;
        wdata = '0;  // not driven to the pins on reads
        write = 1'b0;
      end
    endcase
  end

endmodule : accumulator_core

//--- hw/bus_bridge_top.sv
// Top level of the pin-limited bus bridge.
// Sequencer, four byte lanes, pin multiplexer and the accumulator core.
// Each core bus cycle goes out as a ten-phase frame on 8-bit pins and the
// read word comes back a byte at a time on data_in.

`timescale 1ns/1ps

module bus_bridge_top
  import bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  byte_t data_in,
  output byte_t addr_pins,
  output byte_t data_out,
  output logic  data_oe,
  output logic  addr_strobe
);

  phase_t    phase;
  logic      core_step;
  lane_sel_t addr_sel;
  lane_sel_t read_sel;

  word_t core_addr;
  word_t core_wdata;
  word_t core_rdata;  // lane capture bytes, lane 0 is lsb
  logic  core_write;

  byte_t lane_addr  [NUM_LANES];
  byte_t lane_data  [NUM_LANES];
  byte_t lane_rdata [NUM_LANES];

  bus_sequencer i_bus_sequencer (
    .clk       (clk),
    .rst_n     (rst_n),
    .phase     (phase),
    .core_step (core_step),
    .addr_sel  (addr_sel),
    .read_sel  (read_sel)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    byte_lane i_byte_lane (
      .clk        (clk),
      .rst_n      (rst_n),
      .addr_byte  (core_addr[BYTE_W*i +: BYTE_W]),
      .wdata_byte (core_wdata[BYTE_W*i +: BYTE_W]),
      .addr_sel   (addr_sel[i]),
      .read_sel   (read_sel[i]),
      .data_in    (data_in),
      .lane_addr  (lane_addr[i]),
      .lane_data  (lane_data[i]),
      .lane_rdata (lane_rdata[i])
    );

    assign core_rdata[BYTE_W*i +: BYTE_W] = lane_rdata[i];
  end

  pin_mux i_pin_mux (
    .clk         (clk),
    .rst_n       (rst_n),
    .phase       (phase),
    .write       (core_write),
    .lane_addr   (lane_addr),
    .lane_data   (lane_data),
    .addr_pins   (addr_pins),
    .data_out    (data_out),
    .data_oe     (data_oe),
    .addr_strobe (addr_strobe)
  );

  accumulator_core i_accumulator_core (
    .clk   (clk),
    .rst_n (rst_n),
    .step  (core_step),
    .rdata (core_rdata),
    .addr  (core_addr),
    .wdata (core_wdata),
    .write (core_write)
  );

endmodule : bus_bridge_top

//--- verification/bus_checker.sv
// Pin monitor for the bus bridge testbench.
// Keeps its own pc and running sum, fed from the data_in bytes it samples,
// and compares every pin cycle of every frame against the frame rules.
// All signals are sampled on the rising clock edge.

`timescale 1ns/1ps

module bus_checker
  import bus_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  byte_t addr_pins,
  input  byte_t data_out,
  input  logic  data_oe,
  input  logic  addr_strobe,
  input  byte_t data_in,
  input  word_t exp_sum,
  input  logic  exp_valid,
  output int    value_errors,
  output int    timeouts,
  output int    frames_seen
);

  localparam int WAIT_LIMIT = 30;  // cycles without a strobe
  localparam int MARK_POS   = 4;   // marker cycle, also first read byte

  word_t pc = '0;
  word_t acc = '0;
  word_t rd_word = '0;
  word_t wr_word = '0;   // data_out bytes of the current write frame
  word_t frame_addr = '0;
  logic  is_write = 1'b0;
  logic  in_frame = 1'b0;
  logic  seen_first = 1'b0;
  logic  rst_prev = 1'b0;
  int    pos = 0;        // cycles since the strobe
  int    wait_cnt = 0;

  initial begin
    value_errors = 0;
    timeouts     = 0;
    frames_seen  = 0;
  end

  task automatic compare(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_idle(input string where);
    compare({"addr_pins ", where}, addr_pins, '0);
    compare({"data_out ", where}, data_out, '0);
    compare({"data_oe ", where}, data_oe, '0);
    compare({"addr_strobe ", where}, addr_strobe, '0);
  endtask

  task automatic start_frame();
    in_frame   = 1'b1;
    seen_first = 1'b1;
    pos        = 0;
    wait_cnt   = 0;
    rd_word    = '0;
    wr_word    = '0;
    frame_addr = is_write ? STORE_BASE + pc : pc;
    frames_seen++;
  endtask

  task automatic check_frame_cycle();
    byte_t exp_addr;
    byte_t exp_data;
    exp_addr = '0;
    exp_data = '0;
    if (pos < NUM_LANES) begin
      exp_addr = frame_addr[BYTE_W*pos +: BYTE_W];  // lsb first
      if (is_write) exp_data = acc[BYTE_W*pos +: BYTE_W];
    end else if (pos == MARK_POS) begin
      exp_addr = {7'b0, is_write};
    end
    compare("addr_pins", addr_pins, exp_addr);
    compare("data_out", data_out, exp_data);
    compare("data_oe", data_oe, is_write);
    if (!is_write && pos >= MARK_POS && pos < MARK_POS + NUM_LANES) begin
      rd_word[BYTE_W*(pos - MARK_POS) +: BYTE_W] = data_in;
    end
    if (is_write && pos < NUM_LANES) begin
      wr_word[BYTE_W*pos +: BYTE_W] = data_out;
    end
    if (is_write && pos == NUM_LANES - 1 && exp_valid) begin
      compare("write word against table", wr_word, exp_sum);
    end
    // frame done, step the model like the core does
    if (pos == FRAME_PHASES - 1) begin
      if (is_write) pc = pc + PC_STEP;
      else acc = acc + rd_word;
      is_write = !is_write;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      if (rst_prev) check_idle("in reset");  // first reset cycle still shows old pins
      rst_prev   = 1'b1;
      in_frame   = 1'b0;
      seen_first = 1'b0;
      wait_cnt   = 0;
      pc         = '0;
      acc        = '0;
      is_write   = 1'b0;
    end else begin
      rst_prev = 1'b0;
      if (in_frame) begin
        pos++;
        if (pos == FRAME_PHASES) begin
          if (addr_strobe) begin
            start_frame();
          end else begin
            timeouts++;
            $display("addr_strobe missing %0d cycles after the previous one, at %0t ns",
                     FRAME_PHASES, $time);
            in_frame = 1'b0;
            wait_cnt = 0;
          end
        end else begin
          compare("addr_strobe inside frame", addr_strobe, '0);
        end
      end else if (addr_strobe) begin
        start_frame();
      end else begin
        if (!seen_first) check_idle("before first strobe");
        wait_cnt++;
        if (wait_cnt == WAIT_LIMIT) begin
          timeouts++;
          $display("no addr_strobe for %0d cycles, at %0t ns", WAIT_LIMIT, $time);
        end
      end
      if (in_frame) check_frame_cycle();
    end
  end

endmodule : bus_checker

//--- verification/tb_bus_bridge.sv
// Testbench for the pin-limited bus bridge.
// Plays read words from a table onto data_in in each frame and resets the DUT
// partway through, then replays the table from its start.
// bus_checker watches the pins and does all the comparing.

`timescale 1ns/1ps

module tb_bus_bridge
  import bus_pkg::*;
();

  localparam int NUM_ROWS       = 8;
  localparam int RST_CYCLES     = 4;
  localparam int MID_RST_ROW    = 4;   // last row before the second reset
  localparam int STROBE_TIMEOUT = 30;  // cycles

  logic  clk;
  logic  rst_n;
  byte_t data_in;
  byte_t addr_pins;
  byte_t data_out;
  logic  data_oe;
  logic  addr_strobe;
  word_t exp_sum;
  logic  exp_valid;
  int    value_errors;
  int    chk_timeouts;
  int    frames_seen;
  int    tb_timeouts;

  // read word per row, and the running sum expected once it is added
  word_t rd_tbl [NUM_ROWS] = '{
    32'h0403_0201, 32'h1020_3040, 32'hf0e0_d0c0, 32'h0000_00ff,
    32'hff00_0000, 32'h1234_5678, 32'h8765_4321, 32'h6262_6267
  };
  word_t sum_tbl [NUM_ROWS] = '{
    32'h0403_0201, 32'h1423_3241, 32'h0504_0301, 32'h0504_0400,
    32'h0404_0400, 32'h1638_5a78, 32'h9d9d_9d99, 32'h0000_0000
  };

  bus_bridge_top i_bus_bridge_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .data_in     (data_in),
    .addr_pins   (addr_pins),
    .data_out    (data_out),
    .data_oe     (data_oe),
    .addr_strobe (addr_strobe)
  );

  bus_checker i_bus_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .addr_pins    (addr_pins),
    .data_out     (data_out),
    .data_oe      (data_oe),
    .addr_strobe  (addr_strobe),
    .data_in      (data_in),
    .exp_sum      (exp_sum),
    .exp_valid    (exp_valid),
    .value_errors (value_errors),
    .timeouts     (chk_timeouts),
    .frames_seen  (frames_seen)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // returns on the edge that ends the strobe cycle
  task automatic wait_strobe(output logic ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < STROBE_TIMEOUT) begin
      @(posedge clk);
      if (addr_strobe) ok = 1'b1;
      else n++;
    end
    if (!ok) begin
      tb_timeouts++;
      $display("testbench saw no addr_strobe within %0d cycles, at %0t ns",
               STROBE_TIMEOUT, $time);
    end
  endtask

  // one frame, read bytes go out at the edges that begin S+4 to S+7
  task automatic run_frame(input word_t word, input word_t sum,
                           output logic ok, output logic is_read);
    is_read = 1'b0;
    wait_strobe(ok);
    if (ok) begin
      repeat (3) @(posedge clk);
      for (int k = 0; k < NUM_LANES; k++) begin
        data_in <= word[BYTE_W*k +: BYTE_W];
        @(posedge clk);
        if (k == 0) is_read = (addr_pins == 8'h00);  // marker of cycle S+4
      end
      data_in <= '0;
      if (is_read) begin
        exp_sum   <= sum;
        exp_valid <= 1'b1;
      end
    end
  endtask

  // reset lands inside the write frame that follows the last read
  task automatic reset_mid_frame(output logic ok);
    wait_strobe(ok);
    if (ok) begin
      repeat (2) @(posedge clk);
      rst_n     <= 1'b0;
      exp_valid <= 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
    end
  endtask

  task automatic finish_run();
    int total;
    @(negedge clk);  // checker done with the last edge
    total = value_errors + chk_timeouts + tb_timeouts;
    $display("value errors %0d, checker timeouts %0d, testbench timeouts %0d, frames %0d",
             value_errors, chk_timeouts, tb_timeouts, frames_seen);
    if (total == 0 && frames_seen > 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin
    int   row;
    int   last_row;
    logic ok;
    logic is_read;
    rst_n       = 1'b0;
    data_in     = '0;
    exp_sum     = '0;
    exp_valid   = 1'b0;
    tb_timeouts = 0;
    ok          = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (int run = 0; run < 2 && ok; run++) begin
      row      = 0;
      last_row = (run == 0) ? MID_RST_ROW : NUM_ROWS - 1;
      while (row <= last_row && ok) begin
        run_frame(rd_tbl[row], sum_tbl[row], ok, is_read);
        if (ok && is_read) row++;  // write frames repeat the same row
      end
      if (ok && run == 0) reset_mid_frame(ok);
    end

    // let the checker see the last write frame in full
    if (ok) begin
      wait_strobe(ok);
      if (ok) repeat (FRAME_PHASES) @(posedge clk);
    end
    finish_run();
  end

endmodule : tb_bus_bridge

//--- filelist.f
common/bus_pkg.sv
hw/bus_sequencer.sv
hw/byte_lane/byte_lane.sv
hw/pin_mux.sv
hw/accumulator_core.sv
hw/bus_bridge_top.sv
verification/bus_checker.sv
verification/tb_bus_bridge.sv

//--- Bender.yml
# Pin-limited bus bridge with accumulator core.
# RTL top level is bus_bridge_top, testbench top is tb_bus_bridge.

package:
  name: bus_bridge

sources:
  # package first, then the blocks, top level last
  - files:
      - common/bus_pkg.sv
      - hw/bus_sequencer.sv
      - hw/byte_lane/byte_lane.sv
      - hw/pin_mux.sv
      - hw/accumulator_core.sv
      - hw/bus_bridge_top.sv

  # testbench
  - target: test
    files:
      - verification/bus_checker.sv
      - verification/tb_bus_bridge.sv
